// File: flist.f
+incdir+source
source/hl_cmd_pkg.sv
source/hl_ctrl_pkg.sv
source/hl_cmd_regs.sv
source/hl_tr_seq.sv
source/hl_ad9866_spi.sv
source/hl_resp_gen.sv
source/hl_ctrl_top.sv
tb/hl_ctrl_tb.sv

// File: source/hl_ad9866_spi.sv
/* Codec serial port writer */

`default_nettype none

`include "hl_consts.svh"

module hl_ad9866_spi
  import hl_ctrl_pkg::*;
(
  input  wire             clk_ctrl,
  input  wire             rst_i,

  input  wire spi_word_t  spi_word_i,
  input  wire             spi_start_i,
  output logic            spi_busy_o,

  // Three-wire port to the AD9866
  output logic            rffe_ad9866_sclk_o,
  output logic            rffe_ad9866_sdio_o,
  output logic            rffe_ad9866_sen_n_o
);

  localparam int DIV_W = (`HL_SPI_DIV > 1) ? $clog2(`HL_SPI_DIV) : 1;
  localparam int BIT_W = $clog2(`HL_SPI_W);

  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`HL_SPI_DIV - 1);
  localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`HL_SPI_W - 1);

  spi_state_t        state_q;
  logic [DIV_W-1:0]  div_q;
  logic [BIT_W-1:0]  bit_q;
  logic              sclk_q;
  spi_word_t         shift_q;

  ////////////////////
  // Frame control

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      state_q <= IDLE;
      div_q   <= '0;
      bit_q   <= '0;
      sclk_q  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (spi_start_i) begin
            state_q <= SHIFT;
            div_q   <= '0;
            bit_q   <= '0;
            sclk_q  <= 1'b0;
          end
        end
        SHIFT: begin
          if (div_q == DIV_LAST) begin
            div_q  <= '0;
            sclk_q <= ~sclk_q;
            // Falling edge, advance to the next bit or close the frame
            if (sclk_q) begin
              if (bit_q == BIT_LAST) begin
                state_q <= DONE;
              end else begin
                bit_q <= bit_q + 1'b1;
              end
            end
          end else begin
            div_q <= div_q + 1'b1;
          end
        end
        DONE: begin
          state_q <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // Data shifts out MSB first, moving on each falling sclk
  always_ff @(posedge clk_ctrl) begin
    if (state_q == IDLE && spi_start_i) begin
      shift_q <= spi_word_i;
    end else if (state_q == SHIFT && div_q == DIV_LAST && sclk_q) begin
      shift_q <= {shift_q[`HL_SPI_W-2:0], 1'b0};
    end
  end

  ////////////////////
  // Port pins

  assign rffe_ad9866_sclk_o  = sclk_q;
  assign rffe_ad9866_sen_n_o = (state_q != SHIFT);
  // Held low outside a frame
  assign rffe_ad9866_sdio_o  = (state_q == SHIFT) & shift_q[`HL_SPI_W-1];
  assign spi_busy_o          = (state_q != IDLE);

endmodule

`default_nettype wire

// File: source/hl_cmd_pkg.sv
/* Host command bus types */

`default_nettype none

`include "hl_consts.svh"

package hl_cmd_pkg;

  ////////////////////
  // Command bus

  // Register address carried with each request
  typedef logic [`HL_CMD_ADDR_W-1:0] cmd_addr_t;

  // Payload, only the low bits matter for most registers
  typedef logic [`HL_CMD_DATA_W-1:0] cmd_data_t;

  ////////////////////
  // Response side

  // Word returned to the host on request
  typedef logic [`HL_RESP_W-1:0] resp_t;

  // Codec PGA gain code, also echoed in the response
  typedef logic [`HL_PGA_W-1:0] pga_gain_t;

endpackage

`default_nettype wire

// File: source/hl_cmd_regs.sv
/* Command decode and config registers */

`default_nettype none

`include "hl_consts.svh"

module hl_cmd_regs
  import hl_cmd_pkg::*, hl_ctrl_pkg::*;
(
  input  wire              clk_ctrl,
  input  wire              rst_i,

  // Host command bus
  input  wire cmd_addr_t   cmd_addr_i,
  input  wire cmd_data_t   cmd_data_i,
  input  wire              cmd_rqst_i,
  input  wire              cmd_ptt_i,

  // Codec serial writer
  input  wire              spi_busy_i,
  output spi_word_t        spi_word_o,
  output logic             spi_start_o,

  // Steering outputs
  output pga_gain_t        pga_gain_o,
  output logic             ptt_o,
  output logic             pa_enable_o,
  output logic             cw_enable_o
);

  logic spi_block;
  logic spi_wr;

  // Writer is also unavailable in the cycle the start pulse is out,
  // since its busy flag only rises one cycle later
  assign spi_block = spi_busy_i | spi_start_o;

  // Serial write accepted; a write while blocked is simply lost
  assign spi_wr = cmd_rqst_i & (cmd_addr_i == `HL_ADDR_CODEC_SPI) & ~spi_block;

  ////////////////////
  // Control registers

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      pga_gain_o  <= '0;
      ptt_o       <= 1'b0;
      pa_enable_o <= 1'b0;
      cw_enable_o <= 1'b0;
      spi_start_o <= 1'b0;
    end else begin
      spi_start_o <= spi_wr;
      if (cmd_rqst_i) begin
        // PTT rides along with every command
        ptt_o <= cmd_ptt_i;
        case (cmd_addr_i)
          `HL_ADDR_RXGAIN: begin
            pga_gain_o <= cmd_data_i[`HL_PGA_W-1:0];
          end
          `HL_ADDR_TXCTRL: begin
            pa_enable_o <= cmd_data_i[`HL_TXCTRL_PA_BIT];
            cw_enable_o <= cmd_data_i[`HL_TXCTRL_CW_BIT];
          end
          default: begin
          end
        endcase
      end
    end
  end

  ////////////////////
  // Serial payload

  // Loaded together with the start pulse, held until the next write
  always_ff @(posedge clk_ctrl) begin
    if (spi_wr) begin
      spi_word_o <= cmd_data_i[`HL_SPI_W-1:0];
    end
  end

endmodule

`default_nettype wire

// File: source/hl_consts.svh
/* Control domain constants */

`ifndef HL_CONSTS_SVH
`define HL_CONSTS_SVH

////////////////////
// Bus widths

`define HL_CMD_ADDR_W      6
`define HL_CMD_DATA_W      32
`define HL_RESP_W          40
`define HL_PGA_W           6
`define HL_SPI_W           16

////////////////////
// Command addresses

`define HL_ADDR_TXCTRL     6'h09
`define HL_ADDR_RXGAIN     6'h0A
`define HL_ADDR_CODEC_SPI  6'h3B

// Bit positions inside the transmit control word
`define HL_TXCTRL_PA_BIT   0
`define HL_TXCTRL_CW_BIT   1

////////////////////
// Timing in clk_ctrl cycles

// Half period of the codec serial clock
`define HL_SPI_DIV         4
// Key to transmit enable
`define HL_TR_DELAY        20
// Antenna switch hold after release
`define HL_TR_HANG         30

// Board identity reported in every response
`define HL_SERIALNO        61

`endif

// File: source/hl_ctrl_pkg.sv
/* Sequencer and codec port types */

`default_nettype none

`include "hl_consts.svh"

package hl_ctrl_pkg;

  ////////////////////
  // T/R sequencer

  // RX idle, TX_WAIT with switch thrown, TX keyed, HANG holding switch
  typedef enum logic [1:0] {
    RX,
    TX_WAIT,
    TX,
    HANG
  } tr_state_t;

  ////////////////////
  // Codec serial port

  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    DONE
  } spi_state_t;

  // One codec configuration write
  typedef logic [`HL_SPI_W-1:0] spi_word_t;

endpackage

`default_nettype wire

// File: source/hl_ctrl_top.sv
/* Control domain top level */

`default_nettype none

module hl_ctrl_top
  import hl_cmd_pkg::*, hl_ctrl_pkg::*;
(
  input  wire             clk_ctrl,
  input  wire             rst_i,

  // Host command stream
  input  wire cmd_addr_t  cmd_addr_i,
  input  wire cmd_data_t  cmd_data_i,
  input  wire             cmd_rqst_i,
  input  wire             cmd_ptt_i,
  input  wire             cmd_requires_resp_i,

  input  wire             rxclip_i,
  input  wire             rxgoodlvl_i,
  input  wire             io_phone_tip_i,

  // Response to the host
  output resp_t           resp_o,
  output logic            resp_rqst_o,
  output logic            rxclrstatus_o,

  // T/R switching
  output logic            tx_on_o,
  output logic            rffe_rfsw_sel_o,
  output logic            pa_tr_o,

  // AD9866 control
  output pga_gain_t       rffe_ad9866_pga_o,
  output logic            rffe_ad9866_sclk_o,
  output logic            rffe_ad9866_sdio_o,
  output logic            rffe_ad9866_sen_n_o
);

  logic       ptt;
  logic       pa_enable;
  logic       cw_enable;
  spi_word_t  spi_word;
  logic       spi_start;
  logic       spi_busy;

  ////////////////////
  // Command registers

  hl_cmd_regs u_cmd_regs (
    .clk_ctrl    (clk_ctrl),
    .rst_i       (rst_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_data_i  (cmd_data_i),
    .cmd_rqst_i  (cmd_rqst_i),
    .cmd_ptt_i   (cmd_ptt_i),
    .spi_busy_i  (spi_busy),
    .spi_word_o  (spi_word),
    .spi_start_o (spi_start),
    .pga_gain_o  (rffe_ad9866_pga_o),
    .ptt_o       (ptt),
    .pa_enable_o (pa_enable),
    .cw_enable_o (cw_enable)
  );

  ////////////////////
  // Switching and codec port

  hl_tr_seq u_tr_seq (
    .clk_ctrl        (clk_ctrl),
    .rst_i           (rst_i),
    .ptt_i           (ptt),
    .cw_enable_i     (cw_enable),
    .pa_enable_i     (pa_enable),
    .io_phone_tip_i  (io_phone_tip_i),
    .tx_on_o         (tx_on_o),
    .rffe_rfsw_sel_o (rffe_rfsw_sel_o),
    .pa_tr_o         (pa_tr_o)
  );

  hl_ad9866_spi u_ad9866_spi (
    .clk_ctrl            (clk_ctrl),
    .rst_i               (rst_i),
    .spi_word_i          (spi_word),
    .spi_start_i         (spi_start),
    .spi_busy_o          (spi_busy),
    .rffe_ad9866_sclk_o  (rffe_ad9866_sclk_o),
    .rffe_ad9866_sdio_o  (rffe_ad9866_sdio_o),
    .rffe_ad9866_sen_n_o (rffe_ad9866_sen_n_o)
  );

  ////////////////////
  // Response path

  hl_resp_gen u_resp_gen (
    .clk_ctrl            (clk_ctrl),
    .rst_i               (rst_i),
    .cmd_addr_i          (cmd_addr_i),
    .cmd_rqst_i          (cmd_rqst_i),
    .cmd_requires_resp_i (cmd_requires_resp_i),
    .ptt_i               (ptt),
    .tx_on_i             (tx_on_o),
    .pga_gain_i          (rffe_ad9866_pga_o),
    .rxclip_i            (rxclip_i),
    .rxgoodlvl_i         (rxgoodlvl_i),
    .resp_o              (resp_o),
    .resp_rqst_o         (resp_rqst_o),
    .rxclrstatus_o       (rxclrstatus_o)
  );

endmodule

`default_nettype wire

// File: source/hl_resp_gen.sv
/* Status and response builder */

`default_nettype none

`include "hl_consts.svh"

module hl_resp_gen
  import hl_cmd_pkg::*;
(
  input  wire             clk_ctrl,
  input  wire             rst_i,

  input  wire cmd_addr_t  cmd_addr_i,
  input  wire             cmd_rqst_i,
  input  wire             cmd_requires_resp_i,

  // Live state from the register block and sequencer
  input  wire             ptt_i,
  input  wire             tx_on_i,
  input  wire pga_gain_t  pga_gain_i,

  // Receive level flags from the codec side
  input  wire             rxclip_i,
  input  wire             rxgoodlvl_i,

  output resp_t           resp_o,
  output logic            resp_rqst_o,
  output logic            rxclrstatus_o
);

  logic       rqst_q;
  cmd_addr_t  addr_q;
  logic       clip_q;
  logic       good_q;
  logic       clip_now;
  logic       good_now;

  // Include a flag arriving in the sampling cycle so it is not lost
  assign clip_now = clip_q | rxclip_i;
  assign good_now = good_q | rxgoodlvl_i;

  // Address echo, taken with every request
  always_ff @(posedge clk_ctrl) begin
    if (cmd_rqst_i) begin
      addr_q <= cmd_addr_i;
    end
  end

  ////////////////////
  // Response and sticky status

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      rqst_q      <= 1'b0;
      resp_rqst_o <= 1'b0;
      clip_q      <= 1'b0;
      good_q      <= 1'b0;
      resp_o      <= '0;
    end else begin
      // One stage of delay lets the registers settle first
      rqst_q      <= cmd_rqst_i & cmd_requires_resp_i;
      resp_rqst_o <= rqst_q;
      if (rqst_q) begin
        // addr, tx_on, ptt, serial, gain byte, 14 spare, clip, good
        resp_o <= {addr_q, tx_on_i, ptt_i, 8'(`HL_SERIALNO),
                   2'b00, pga_gain_i, 14'd0, clip_now, good_now};
        clip_q <= 1'b0;
        good_q <= 1'b0;
      end else begin
        clip_q <= clip_now;
        good_q <= good_now;
      end
    end
  end

  // Status clear goes out with the response
  assign rxclrstatus_o = resp_rqst_o;

endmodule

`default_nettype wire

// File: source/hl_tr_seq.sv
/* Transmit/receive sequencer */

`default_nettype none

`include "hl_consts.svh"

module hl_tr_seq
  import hl_ctrl_pkg::*;
(
  input  wire   clk_ctrl,
  input  wire   rst_i,

  input  wire   ptt_i,
  input  wire   cw_enable_i,
  input  wire   pa_enable_i,
  // CW key, low when pressed
  input  wire   io_phone_tip_i,

  output logic  tx_on_o,
  output logic  rffe_rfsw_sel_o,
  output logic  pa_tr_o
);

  localparam int CNT_W = $clog2(`HL_TR_DELAY + `HL_TR_HANG);

  // TX_WAIT runs from the cycle after the key up to one before tx_on
  localparam logic [CNT_W-1:0] DELAY_LOAD = CNT_W'(`HL_TR_DELAY - 2);
  // HANG spans the full hold time after tx_on drops
  localparam logic [CNT_W-1:0] HANG_LOAD  = CNT_W'(`HL_TR_HANG - 1);

  tr_state_t         state_q;
  logic [CNT_W-1:0]  cnt_q;
  logic              key;
  logic              sw_on;

  // PTT from the host or the paddle when CW keying is allowed
  assign key = ptt_i | (cw_enable_i & ~io_phone_tip_i);

  ////////////////////
  // State machine

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      state_q <= RX;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        RX: begin
          if (key) begin
            state_q <= TX_WAIT;
            cnt_q   <= DELAY_LOAD;
          end
        end
        TX_WAIT: begin
          // Released before transmit started, still hold the switch
          if (!key) begin
            state_q <= HANG;
            cnt_q   <= HANG_LOAD;
          end else if (cnt_q == '0) begin
            state_q <= TX;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        TX: begin
          if (!key) begin
            state_q <= HANG;
            cnt_q   <= HANG_LOAD;
          end
        end
        HANG: begin
          // Re-key restarts the full delay
          if (key) begin
            state_q <= TX_WAIT;
            cnt_q   <= DELAY_LOAD;
          end else if (cnt_q == '0) begin
            state_q <= RX;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        default: begin
          state_q <= RX;
        end
      endcase
    end
  end

  ////////////////////
  // Outputs

  assign sw_on           = (state_q != RX);
  assign rffe_rfsw_sel_o = sw_on;
  assign pa_tr_o         = sw_on & pa_enable_i;
  assign tx_on_o         = (state_q == TX);

endmodule

`default_nettype wire

// File: tb/hl_ctrl_tb.sv
/* Control domain testbench */

`default_nettype none

`include "hl_consts.svh"

module hl_ctrl_tb
  import hl_cmd_pkg::*, hl_ctrl_pkg::*;
();

  localparam int FRAME_CYCLES = 2 * `HL_SPI_DIV * `HL_SPI_W + 4;
  localparam int TR_CYCLES    = `HL_TR_DELAY + `HL_TR_HANG;
  // Reset, gain, serial, T/R and response tests, then a margin
  localparam int RUN_CYCLES   = 20 + 60 + 5 * FRAME_CYCLES + 10 * TR_CYCLES
                                + 4 * TR_CYCLES + 200;
  localparam int CNT_CAP      = 1000;

  logic       clk_ctrl;
  logic       rst_i;
  cmd_addr_t  cmd_addr_i;
  cmd_data_t  cmd_data_i;
  logic       cmd_rqst_i;
  logic       cmd_ptt_i;
  logic       cmd_requires_resp_i;
  logic       rxclip_i;
  logic       rxgoodlvl_i;
  logic       io_phone_tip_i;

  resp_t      resp_o;
  logic       resp_rqst_o;
  logic       rxclrstatus_o;
  logic       tx_on_o;
  logic       rffe_rfsw_sel_o;
  logic       pa_tr_o;
  pga_gain_t  rffe_ad9866_pga_o;
  logic       rffe_ad9866_sclk_o;
  logic       rffe_ad9866_sdio_o;
  logic       rffe_ad9866_sen_n_o;

  integer     seed;
  int         err_cnt;
  int         err_mark;
  int         test_cnt;
  logic       idle_chk;

  // Addresses that must not touch any register
  cmd_addr_t  other_addr [4] = '{6'h00, 6'h0B, 6'h20, 6'h3A};

  hl_ctrl_top DUT (
    .clk_ctrl            (clk_ctrl),
    .rst_i               (rst_i),
    .cmd_addr_i          (cmd_addr_i),
    .cmd_data_i          (cmd_data_i),
    .cmd_rqst_i          (cmd_rqst_i),
    .cmd_ptt_i           (cmd_ptt_i),
    .cmd_requires_resp_i (cmd_requires_resp_i),
    .rxclip_i            (rxclip_i),
    .rxgoodlvl_i         (rxgoodlvl_i),
    .io_phone_tip_i      (io_phone_tip_i),
    .resp_o              (resp_o),
    .resp_rqst_o         (resp_rqst_o),
    .rxclrstatus_o       (rxclrstatus_o),
    .tx_on_o             (tx_on_o),
    .rffe_rfsw_sel_o     (rffe_rfsw_sel_o),
    .pa_tr_o             (pa_tr_o),
    .rffe_ad9866_pga_o   (rffe_ad9866_pga_o),
    .rffe_ad9866_sclk_o  (rffe_ad9866_sclk_o),
    .rffe_ad9866_sdio_o  (rffe_ad9866_sdio_o),
    .rffe_ad9866_sen_n_o (rffe_ad9866_sen_n_o)
  );

  initial begin
    clk_ctrl = 1'b0;
    forever #4 clk_ctrl = ~clk_ctrl;
  end

  ////////////////////
  // Expected registers and T/R timing

  pga_gain_t  gain_m;
  logic       ptt_m;
  logic       pa_m;
  logic       cw_m;
  logic       key_m;
  int         key_run;
  int         since_key;
  logic       exp_tx;
  logic       exp_sw;
  resp_t      exp_resp;

  // Key in the current cycle, from host PTT or the paddle
  assign key_m  = ptt_m | (cw_m & ~io_phone_tip_i);
  // Transmit only once the key has been held for the full delay
  assign exp_tx = (key_run >= `HL_TR_DELAY);
  // Switch held until the hang time after tx_on drops has run out
  assign exp_sw = (since_key <= `HL_TR_HANG);

  always @(posedge clk_ctrl) begin
    if (rst_i) begin
      gain_m    <= '0;
      ptt_m     <= 1'b0;
      pa_m      <= 1'b0;
      cw_m      <= 1'b0;
      key_run   <= 0;
      since_key <= CNT_CAP;
    end else begin
      if (cmd_rqst_i) begin
        ptt_m <= cmd_ptt_i;
        if (cmd_addr_i == `HL_ADDR_RXGAIN) begin
          gain_m <= cmd_data_i[`HL_PGA_W-1:0];
        end
        if (cmd_addr_i == `HL_ADDR_TXCTRL) begin
          pa_m <= cmd_data_i[0];
          cw_m <= cmd_data_i[1];
        end
      end
      if (key_m) begin
        key_run   <= (key_run < CNT_CAP) ? key_run + 1 : key_run;
        since_key <= 0;
      end else begin
        key_run   <= 0;
        since_key <= (since_key < CNT_CAP) ? since_key + 1 : since_key;
      end
    end
  end

  ////////////////////
  // Codec port and response monitor

  logic       sclk_d;
  logic       sen_d;
  logic       sdio_d;
  resp_t      resp_prev;
  spi_word_t  cap_word;
  int         cap_cnt;
  logic       frame_done;
  logic       frame_unexp;
  spi_word_t  frame_word;
  spi_word_t  frame_exp;
  int         frame_bits;
  int         frames_seen;
  spi_word_t  exp_words [$];

  always @(posedge clk_ctrl) begin
    frame_done <= 1'b0;
    resp_prev  <= resp_o;
    sdio_d     <= rffe_ad9866_sdio_o;
    if (rst_i) begin
      sclk_d      <= 1'b0;
      sen_d       <= 1'b1;
      cap_cnt     <= 0;
      frames_seen <= 0;
    end else begin
      sclk_d <= rffe_ad9866_sclk_o;
      sen_d  <= rffe_ad9866_sen_n_o;
      if (!rffe_ad9866_sen_n_o && sen_d) begin
        cap_cnt  <= 0;
        cap_word <= '0;
      end else if (!rffe_ad9866_sen_n_o && rffe_ad9866_sclk_o && !sclk_d) begin
        // Codec samples on the rising sclk
        cap_word <= {cap_word[`HL_SPI_W-2:0], rffe_ad9866_sdio_o};
        cap_cnt  <= cap_cnt + 1;
      end
      if (rffe_ad9866_sen_n_o && !sen_d) begin
        frame_done  <= 1'b1;
        frame_bits  <= cap_cnt;
        frame_word  <= cap_word;
        frames_seen <= frames_seen + 1;
        if (exp_words.size() > 0) begin
          frame_exp   <= exp_words.pop_front();
          frame_unexp <= 1'b0;
        end else begin
          frame_unexp <= 1'b1;
        end
      end
    end
  end

  ////////////////////
  // Checks

  task automatic report_mismatch(input string sig, input logic [63:0] exp,
                                 input logic [63:0] act);
    err_cnt++;
    $display("[ERROR] t=%0t %s expected 'h%0h got 'h%0h", $time, sig, exp, act);
  endtask

  assert property (@(posedge clk_ctrl) disable iff (rst_i)
    rffe_ad9866_pga_o == gain_m)
    else report_mismatch("rffe_ad9866_pga_o", $sampled(gain_m),
                         $sampled(rffe_ad9866_pga_o));

  assert property (@(posedge clk_ctrl) disable iff (rst_i) tx_on_o == exp_tx)
    else report_mismatch("tx_on_o", $sampled(exp_tx), $sampled(tx_on_o));

  assert property (@(posedge clk_ctrl) disable iff (rst_i) rffe_rfsw_sel_o == exp_sw)
    else report_mismatch("rffe_rfsw_sel_o", $sampled(exp_sw), $sampled(rffe_rfsw_sel_o));

  assert property (@(posedge clk_ctrl) disable iff (rst_i) pa_tr_o == (exp_sw & pa_m))
    else report_mismatch("pa_tr_o", $sampled(exp_sw & pa_m), $sampled(pa_tr_o));

  // Response pulse two cycles after a request that asks for one
  assert property (@(posedge clk_ctrl) disable iff (rst_i)
    resp_rqst_o == $past(cmd_rqst_i & cmd_requires_resp_i, 2))
    else report_mismatch("resp_rqst_o", !$sampled(resp_rqst_o), $sampled(resp_rqst_o));

  // Status clear pulses with the same delay
  assert property (@(posedge clk_ctrl) disable iff (rst_i)
    rxclrstatus_o == $past(cmd_rqst_i & cmd_requires_resp_i, 2))
    else report_mismatch("rxclrstatus_o", !$sampled(rxclrstatus_o), $sampled(rxclrstatus_o));

  assert property (@(posedge clk_ctrl) disable iff (rst_i) resp_rqst_o |-> resp_o == exp_resp)
    else report_mismatch("resp_o", $sampled(exp_resp), $sampled(resp_o));

  assert property (@(posedge clk_ctrl) disable iff (rst_i)
    !resp_rqst_o |-> resp_o == resp_prev)
    else report_mismatch("resp_o", $sampled(resp_prev), $sampled(resp_o));

  // Data must not move on a rising sclk
  assert property (@(posedge clk_ctrl) disable iff (rst_i)
    (!rffe_ad9866_sen_n_o && rffe_ad9866_sclk_o && !sclk_d) |-> rffe_ad9866_sdio_o == sdio_d)
    else report_mismatch("rffe_ad9866_sdio_o", $sampled(sdio_d), $sampled(rffe_ad9866_sdio_o));

  assert property (@(posedge clk_ctrl) disable iff (rst_i) frame_done |-> !frame_unexp)
    else begin
      err_cnt++;
      $display("[ERROR] t=%0t codec serial frame seen where none was sent", $time);
    end

  assert property (@(posedge clk_ctrl) disable iff (rst_i)
    (frame_done && !frame_unexp) |-> frame_bits == `HL_SPI_W)
    else report_mismatch("rffe_ad9866_sclk_o edges", `HL_SPI_W, $sampled(frame_bits));

  assert property (@(posedge clk_ctrl) disable iff (rst_i)
    (frame_done && !frame_unexp) |-> frame_word == frame_exp)
    else report_mismatch("rffe_ad9866_sdio_o word", $sampled(frame_exp), $sampled(frame_word));

  assert property (@(posedge clk_ctrl) disable iff (rst_i) idle_chk |-> rffe_ad9866_sen_n_o)
    else report_mismatch("rffe_ad9866_sen_n_o", 1, $sampled(rffe_ad9866_sen_n_o));

  assert property (@(posedge clk_ctrl) disable iff (rst_i) idle_chk |-> !rffe_ad9866_sclk_o)
    else report_mismatch("rffe_ad9866_sclk_o", 0, $sampled(rffe_ad9866_sclk_o));

  assert property (@(posedge clk_ctrl) disable iff (rst_i) idle_chk |-> resp_o == '0)
    else report_mismatch("resp_o", 0, $sampled(resp_o));

  ////////////////////
  // Stimulus helpers

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_ctrl);
  endtask

  task automatic send_cmd(input cmd_addr_t addr, input cmd_data_t data,
                          input logic ptt, input logic resp);
    @(posedge clk_ctrl);
    cmd_addr_i          <= addr;
    cmd_data_i          <= data;
    cmd_ptt_i           <= ptt;
    cmd_requires_resp_i <= resp;
    cmd_rqst_i          <= 1'b1;
    @(posedge clk_ctrl);
    cmd_rqst_i          <= 1'b0;
    cmd_requires_resp_i <= 1'b0;
  endtask

  task automatic pulse_status(input logic clip, input logic good);
    @(posedge clk_ctrl);
    rxclip_i    <= clip;
    rxgoodlvl_i <= good;
    @(posedge clk_ctrl);
    rxclip_i    <= 1'b0;
    rxgoodlvl_i <= 1'b0;
  endtask

  task automatic expect_response(input cmd_addr_t addr, input cmd_data_t data,
                                 input logic ptt, input logic tx_bit,
                                 input pga_gain_t gain, input logic clip,
                                 input logic good);
    logic got;
    int   i;
    got      = 1'b0;
    exp_resp = {addr, tx_bit, ptt, 8'(`HL_SERIALNO), 2'b00, gain, 14'd0, clip, good};
    send_cmd(addr, data, ptt, 1'b1);
    for (i = 0; i < 8 && !got; i++) begin
      @(posedge clk_ctrl);
      if (resp_rqst_o) begin
        got = 1'b1;
      end
    end
    if (!got) begin
      err_cnt++;
      $display("[ERROR] t=%0t no response pulse after a request for one", $time);
    end
  endtask

  task automatic wait_frames(input int target, input int limit);
    int n;
    n = 0;
    while (frames_seen < target && n < limit) begin
      @(posedge clk_ctrl);
      n++;
    end
    if (frames_seen < target) begin
      err_cnt++;
      $display("[ERROR] t=%0t codec serial frame did not finish in time", $time);
    end
  endtask

  task automatic end_test(input string name);
    $display("%-24s done, %0d error(s)", name, err_cnt - err_mark);
    err_mark = err_cnt;
    test_cnt++;
  endtask

  ////////////////////
  // Test sequence

  initial begin
    cmd_data_t  data;
    pga_gain_t  g1;
    pga_gain_t  g3;
    int         k;
    seed                = 79666;
    err_cnt             = 0;
    err_mark            = 0;
    test_cnt            = 0;
    idle_chk            = 1'b0;
    exp_resp            = '0;
    rst_i               = 1'b1;
    cmd_addr_i          = '0;
    cmd_data_i          = '0;
    cmd_rqst_i          = 1'b0;
    cmd_ptt_i           = 1'b0;
    cmd_requires_resp_i = 1'b0;
    rxclip_i            = 1'b0;
    rxgoodlvl_i         = 1'b0;
    io_phone_tip_i      = 1'b1;
    repeat (3) @(posedge clk_ctrl);
    rst_i <= 1'b0;

    // Quiet outputs until the first command
    idle_chk <= 1'b1;
    wait_cycles(12);
    idle_chk <= 1'b0;
    end_test("reset levels");

    for (k = 0; k < 4; k++) begin
      data = $random(seed);
      send_cmd(`HL_ADDR_RXGAIN, data, 1'b0, 1'b0);
      wait_cycles(2);
      data = $random(seed);
      send_cmd(other_addr[k], data, 1'b0, 1'b0);
      wait_cycles(2);
    end
    end_test("gain writes");

    // Second write lands while the first frame is still shifting
    data = $random(seed);
    exp_words.push_back(data[`HL_SPI_W-1:0]);
    send_cmd(`HL_ADDR_CODEC_SPI, data, 1'b0, 1'b0);
    wait_cycles(5);
    data = $random(seed);
    send_cmd(`HL_ADDR_CODEC_SPI, data, 1'b0, 1'b0);
    wait_frames(1, 2 * FRAME_CYCLES);
    wait_cycles(2 * FRAME_CYCLES);
    data = $random(seed);
    exp_words.push_back(data[`HL_SPI_W-1:0]);
    send_cmd(`HL_ADDR_CODEC_SPI, data, 1'b0, 1'b0);
    wait_frames(2, 2 * FRAME_CYCLES);
    end_test("codec serial writes");

    // PTT with the PA disabled
    send_cmd(`HL_ADDR_TXCTRL, 32'h0, 1'b0, 1'b0);
    send_cmd(6'h00, 32'h0, 1'b1, 1'b0);
    wait_cycles(`HL_TR_DELAY + 20);
    send_cmd(6'h00, 32'h0, 1'b0, 1'b0);
    wait_cycles(`HL_TR_HANG + 10);
    // PA keyed, then re-key inside the hang time
    send_cmd(`HL_ADDR_TXCTRL, 32'h1, 1'b0, 1'b0);
    send_cmd(6'h00, 32'h0, 1'b1, 1'b0);
    wait_cycles(`HL_TR_DELAY + 20);
    send_cmd(6'h00, 32'h0, 1'b0, 1'b0);
    wait_cycles(10);
    send_cmd(6'h00, 32'h0, 1'b1, 1'b0);
    wait_cycles(`HL_TR_DELAY + 10);
    send_cmd(6'h00, 32'h0, 1'b0, 1'b0);
    wait_cycles(`HL_TR_HANG + 10);
    end_test("PTT sequencing");

    // Paddle ignored until CW keying is enabled
    @(posedge clk_ctrl);
    io_phone_tip_i <= 1'b0;
    wait_cycles(`HL_TR_DELAY + 10);
    io_phone_tip_i <= 1'b1;
    send_cmd(`HL_ADDR_TXCTRL, 32'h3, 1'b0, 1'b0);
    @(posedge clk_ctrl);
    io_phone_tip_i <= 1'b0;
    wait_cycles(`HL_TR_DELAY + 10);
    io_phone_tip_i <= 1'b1;
    wait_cycles(`HL_TR_HANG + 10);
    end_test("CW key sequencing");

    data = $random(seed);
    g1   = data[`HL_PGA_W-1:0];
    send_cmd(`HL_ADDR_RXGAIN, data, 1'b0, 1'b0);
    pulse_status(1'b1, 1'b0);
    expect_response(6'h00, 32'h0, 1'b0, 1'b0, g1, 1'b1, 1'b0);
    pulse_status(1'b0, 1'b1);
    expect_response(6'h05, 32'h0, 1'b0, 1'b0, g1, 1'b0, 1'b1);
    // Response to a gain write already carries the new gain
    data = $random(seed);
    g3   = data[`HL_PGA_W-1:0];
    expect_response(`HL_ADDR_RXGAIN, data, 1'b0, 1'b0, g3, 1'b0, 1'b0);
    expect_response(6'h00, 32'h0, 1'b1, 1'b0, g3, 1'b0, 1'b0);
    wait_cycles(`HL_TR_DELAY + 5);
    pulse_status(1'b1, 1'b1);
    expect_response(6'h01, 32'h0, 1'b1, 1'b1, g3, 1'b1, 1'b1);
    // tx_on still high in the cycle the release is sampled
    expect_response(6'h02, 32'h0, 1'b0, 1'b1, g3, 1'b0, 1'b0);
    wait_cycles(`HL_TR_HANG + 10);
    end_test("response word");

    wait_cycles(4);
    $display("tests run %0d, errors %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (RUN_CYCLES) @(posedge clk_ctrl);
    $display("Run did not finish within %0d cycles", RUN_CYCLES);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire
